// File: run_sim.sh
#!/usr/bin/env bash
# build and run core_tb with Verilator from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter project directory"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module core_tb -Mdir obj_dir -o core_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/core_tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
	exit 0
else
	exit 1
fi

// File: sim/core_tb.sv
`include "core_defs.svh"

module core_tb import core_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 500;

	logic                clk;
	logic                rst;
	logic                load_en;
	logic [`IMEM_AW-1:0] load_addr;
	logic [`XLEN_W-1:0]  load_data;
	logic                start;
	logic                busy;
	logic                done;
	logic                retire_valid;
	data_t               retire_pc;
	logic [4:0]          retire_rd;
	data_t               retire_data;
	data_t               next_pc;
	data_t               cycle_count;
	data_t               instret_count;

	// program and expected trace from the data file
	data_t      prog_words [$];
	data_t      exp_pc [$];
	logic [4:0] exp_rd [$];
	data_t      exp_data [$];
	data_t      exp_next [$];
	data_t      exp_cycles;
	data_t      exp_instret;

	int   errors;
	int   tests_run;
	int   tests_failed;
	logic timed_out;
	logic file_ok;

	core_top dut0 (.clk(clk), .rst(rst), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .start(start), .busy(busy), .done(done),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
		.retire_data(retire_data), .next_pc(next_pc), .cycle_count(cycle_count),
		.instret_count(instret_count));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got x%0d expected x%0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before && !timed_out) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end
	endtask

	task automatic read_input();
		int    fd;
		int    n;
		int    ch;
		byte   tag;
		data_t w [4];
		fd = $fopen("sim/program_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open sim/program_input.txt");
			file_ok = 1'b0;
			return;
		end
		forever begin
			n = $fscanf(fd, " %c", tag);
			if (n != 1)
				break;
			case (tag)
				"#": begin // comment, drop rest of line
					ch = $fgetc(fd);
					while (ch != "\n" && ch != -1)
						ch = $fgetc(fd);
				end
				"P": begin
					n = $fscanf(fd, "%h %h %h %h", w[0], w[1], w[2], w[3]);
					if (n != 4)
						file_ok = 1'b0;
					for (int i = 0; i < 4; i++)
						prog_words.push_back(w[i]);
				end
				"R": begin
					n = $fscanf(fd, "%h %h %h %h", w[0], w[1], w[2], w[3]);
					if (n != 4)
						file_ok = 1'b0;
					exp_pc.push_back(w[0]);
					exp_rd.push_back(w[1][4:0]);
					exp_data.push_back(w[2]);
					exp_next.push_back(w[3]);
				end
				"C": begin
					n = $fscanf(fd, "%h %h", exp_cycles, exp_instret);
					if (n != 2)
						file_ok = 1'b0;
				end
				default: file_ok = 1'b0;
			endcase
			if (!file_ok)
				break;
		end
		$fclose(fd);
		// two clocks per retired instruction
		if (exp_instret != exp_pc.size() || exp_cycles != 2 * exp_instret)
			file_ok = 1'b0;
		if (prog_words.size() == 0 || prog_words.size() > `IMEM_DEPTH)
			file_ok = 1'b0;
		if (!file_ok)
			$display("sim/program_input.txt is malformed or inconsistent");
	endtask

	task automatic load_program();
		for (int i = 0; i < prog_words.size(); i++) begin
			@(posedge clk);
			load_en   <= 1'b1;
			load_addr <= i[`IMEM_AW-1:0];
			load_data <= prog_words[i];
		end
		@(posedge clk);
		load_en <= 1'b0;
	endtask

	task automatic check_record(input int idx);
		check_data($sformatf("retire_pc[%0d]", idx), retire_pc, exp_pc[idx]);
		check_reg($sformatf("retire_rd[%0d]", idx), retire_rd, exp_rd[idx]);
		check_data($sformatf("retire_data[%0d]", idx), retire_data, exp_data[idx]);
		check_data($sformatf("next_pc[%0d]", idx), next_pc, exp_next[idx]);
	endtask

	task automatic run_program(input int run_no);
		int idx;
		int cycles;
		int errors_before;
		errors_before = errors;
		idx = 0;
		cycles = 0;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		// first FETCH, counters just cleared
		check_count("cycle_count", cycle_count, 0);
		check_count("instret_count", instret_count, 0);
		check_flag("busy", busy, 1'b1);
		check_flag("done", done, 1'b0);
		while (!done && cycles < TIMEOUT_CYCLES) begin
			if (retire_valid) begin
				if (idx < exp_pc.size())
					check_record(idx);
				idx++;
			end
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			$display("timeout: run %0d did not reach done within %0d cycles",
				run_no, TIMEOUT_CYCLES);
			timed_out = 1'b1;
		end else if (idx != exp_pc.size()) begin
			$display("run %0d retired %0d instructions but %0d were expected",
				run_no, idx, exp_pc.size());
			errors++;
		end
		end_test($sformatf("run %0d trace", run_no), errors_before);
	endtask

	task automatic check_halt(input int run_no);
		int errors_before;
		errors_before = errors;
		check_flag("done", done, 1'b1);
		check_flag("busy", busy, 1'b0);
		check_flag("retire_valid", retire_valid, 1'b0);
		check_count("instret_count", instret_count, exp_instret);
		check_count("cycle_count", cycle_count, exp_cycles);
		end_test($sformatf("halt %0d counters", run_no), errors_before);
	endtask

	initial begin
		int errors_before;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		file_ok = 1'b1;
		rst = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		start = 1'b0;
		read_input();
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		errors_before = errors;
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
		check_flag("retire_valid", retire_valid, 1'b0);
		check_count("cycle_count", cycle_count, 0);
		check_count("instret_count", instret_count, 0);
		end_test("reset state", errors_before);
		if (file_ok) begin
			load_program();
			run_program(1);
			if (!timed_out)
				check_halt(1);
			if (!timed_out)
				run_program(2); // same trace again from the reset pc
			if (!timed_out)
				check_halt(2);
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0 && !timed_out && file_ok)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: sim/program_input.txt
# P: four program words in hex, loaded from word address 0 upward
# R: retire pc, rd, data, next pc in hex; C: cycle count and retire count in hex
P 123450B7 00500113 FFD00193 00310233
P 403102B3 0021A333 0021B3B3 0020C433
P 003164B3 00317533 00411593 4011D613
P 01C1D693 00001717 00210463 00000013
P 00310463 00311463 00000013 00211463
P 0021C463 00000013 00314463 00315463
P 00000013 0021D463 00316463 00000013
P 0021E463 0021F463 00000013 00317463
P 0080086F 00000013 09600893 00388967
P 00000013 00000013 0080006F 00000013
P 00710013 002009B3 00100073 00000013
# alu, lui and auipc
R 00 01 12345000 04
R 04 02 00000005 08
R 08 03 fffffffd 0c
R 0c 04 00000002 10
R 10 05 00000008 14
R 14 06 00000001 18
R 18 07 00000000 1c
R 1c 08 12345005 20
R 20 09 fffffffd 24
R 24 0a 00000005 28
R 28 0b 00000050 2c
R 2c 0c fffffffe 30
R 30 0d 0000000f 34
R 34 0e 00001034 38
# branches, taken then not taken for each kind
R 38 00 00000000 40
R 40 00 00000000 44
R 44 00 00000000 4c
R 4c 00 00000000 50
R 50 00 00000000 58
R 58 00 00000000 5c
R 5c 00 00000000 64
R 64 00 00000000 68
R 68 00 00000000 70
R 70 00 00000000 74
R 74 00 00000000 7c
R 7c 00 00000000 80
# jal, jalr with odd target, x0 writes, ebreak
R 80 10 00000084 88
R 88 11 00000096 8c
R 8c 12 00000090 98
R 98 00 00000000 a0
R a0 00 00000000 a4
R a4 13 00000005 a8
R a8 00 00000000 ac
C 42 21

// File: source/alu.sv
module alu import rv_isa_pkg::*, core_pkg::*; (
	input  instr_t instr,
	input  data_t  pc,
	input  data_t  rs1,
	input  data_t  rs2,

	output data_t  result,
	output logic   wr_en
);

	opcode_t    opcode;
	funct3_t    funct3;
	logic       alt;     // funct7[5], sub and sra
	data_t      imm;
	data_t      op_b;
	logic [4:0] shamt;

	assign opcode = instr.r.opcode;
	assign funct3 = instr.r.funct3;
	assign alt    = instr.r.funct7[5];
	assign imm    = get_imm(instr);
	assign op_b   = (opcode == OP) ? rs2 : imm;
	assign shamt  = op_b[4:0];

	always_comb begin
		result = '0;
		case (opcode)
			OP, OP_IMM: begin
				case (funct3)
					F3_ADD:  result = (opcode == OP && alt) ? rs1 - op_b : rs1 + op_b;
					F3_SLL:  result = rs1 << shamt;
					F3_SLT:  result = {31'b0, $signed(rs1) < $signed(op_b)};
					F3_SLTU: result = {31'b0, rs1 < op_b};
					F3_XOR:  result = rs1 ^ op_b;
					F3_SR:   result = alt ? data_t'($signed(rs1) >>> shamt) : rs1 >> shamt;
					F3_OR:   result = rs1 | op_b;
					default: result = rs1 & op_b;
				endcase
			end
			LUI:       result = imm;
			AUIPC:     result = pc + imm;
			JAL, JALR: result = pc + 32'd4; // link
			default:   result = '0;
		endcase
	end

	assign wr_en = (opcode inside {OP, OP_IMM, LUI, AUIPC, JAL, JALR}) &&
		(instr.r.rd != 5'd0);

endmodule

// File: source/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and memory geometry
`define XLEN_W      32
`define IMEM_DEPTH  64
`define IMEM_AW     6

`define RESET_PC    32'h0000_0000

`endif

// File: source/core_fsm.sv
`include "core_defs.svh"

module core_fsm import rv_isa_pkg::*, core_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  instr_t      instr,
	input  logic        bj_sel,
	input  data_t       pc_bj,

	output core_state_t state,
	output data_t       pc,
	output logic        retire_valid,
	output logic        busy,
	output logic        done,
	output data_t       next_pc
);

	wire is_system = (instr.r.opcode == SYSTEM); // ecall / ebreak

	assign next_pc      = bj_sel ? pc_bj : pc + 32'd4;
	assign retire_valid = (state == EXEC);
	assign busy         = (state == FETCH) || (state == EXEC);
	assign done         = (state == HALT);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			pc    <= `RESET_PC;
		end else begin
			case (state)
				IDLE, HALT: if (start) begin
					state <= FETCH;
					pc    <= `RESET_PC;
				end
				FETCH: state <= EXEC;
				default: begin // EXEC
					pc    <= next_pc;
					state <= is_system ? HALT : FETCH;
				end
			endcase
		end
	end

	// every retire follows exactly one fetch cycle
	a_retire_after_fetch: assert property (@(posedge clk) disable iff (rst)
		retire_valid |-> ($past(state) == FETCH) ##1 !retire_valid);

	a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// File: source/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

	typedef logic [`XLEN_W-1:0] data_t;

	// two clocks per instruction, FETCH then EXEC
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		FETCH = 2'd1,
		EXEC  = 2'd2,
		HALT  = 2'd3
	} core_state_t;

endpackage

// File: source/core_top.sv
`include "core_defs.svh"

module core_top import rv_isa_pkg::*, core_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                load_en,
	input  logic [`IMEM_AW-1:0] load_addr,
	input  logic [`XLEN_W-1:0]  load_data,
	input  logic                start,

	output logic                busy,
	output logic                done,
	output logic                retire_valid,
	output data_t               retire_pc,
	output logic [4:0]          retire_rd,
	output data_t               retire_data,
	output data_t               next_pc,
	output data_t               cycle_count,
	output data_t               instret_count
);

	core_state_t state;
	data_t       pc;
	instr_t      instr;
	data_t       pc_bj;
	logic        bj_sel;
	data_t       alu_result;
	logic        alu_wr_en;

	rf_if rf ();

	// datapath side of the register file
	assign rf.rs1_addr = instr.r.rs1;
	assign rf.rs2_addr = instr.r.rs2;
	assign rf.wr_addr  = instr.r.rd;
	assign rf.wr_data  = alu_result;
	assign rf.wr_en    = alu_wr_en && retire_valid; // commit at the EXEC edge

	assign retire_pc   = pc;
	assign retire_rd   = alu_wr_en ? instr.r.rd : 5'd0;
	assign retire_data = alu_wr_en ? alu_result : '0;

	core_fsm fsm0 (.clk(clk), .rst(rst), .start(start), .instr(instr), .bj_sel(bj_sel),
		.pc_bj(pc_bj), .state(state), .pc(pc), .retire_valid(retire_valid),
		.busy(busy), .done(done), .next_pc(next_pc));

	instr_mem imem0 (.clk(clk), .load_en(load_en && state == IDLE), .load_addr(load_addr),
		.load_data(load_data), .rd_addr(pc[`IMEM_AW+1:2]), .rd_instr(instr));

	reg_file rf0 (.clk(clk), .rst(rst), .rf(rf));

	pc_adder pca0 (.instr(instr), .pc(pc), .rs1(rf.rs1_data), .rs2(rf.rs2_data),
		.pc_bj(pc_bj), .bj_sel(bj_sel));

	alu alu0 (.instr(instr), .pc(pc), .rs1(rf.rs1_data), .rs2(rf.rs2_data),
		.result(alu_result), .wr_en(alu_wr_en));

	perf_counter perf0 (.clk(clk), .rst(rst), .start(start), .state(state),
		.retire_valid(retire_valid), .cycle_count(cycle_count),
		.instret_count(instret_count));

endmodule

// File: source/instr_mem.sv
`include "core_defs.svh"

module instr_mem import rv_isa_pkg::*; (
	input  logic                clk,
	input  logic                load_en,
	input  logic [`IMEM_AW-1:0] load_addr,
	input  logic [`XLEN_W-1:0]  load_data,
	input  logic [`IMEM_AW-1:0] rd_addr,
	output instr_t              rd_instr
);

	instr_t mem [`IMEM_DEPTH];

	// only the tb load port writes
	always_ff @(posedge clk) begin
		if (load_en)
			mem[load_addr] <= instr_t'(load_data);
	end

	always_ff @(posedge clk) begin
		rd_instr <= mem[rd_addr]; // valid one clock later, in EXEC
	end

endmodule

// File: source/pc_adder.sv
module pc_adder import rv_isa_pkg::*, core_pkg::*; (
	input  instr_t instr,
	input  data_t  pc,
	input  data_t  rs1,
	input  data_t  rs2,

	output data_t  pc_bj,
	output logic   bj_sel
);

	opcode_t opcode;
	funct3_t funct3;
	logic    cond;
	logic    branch_taken;
	data_t   imm;
	data_t   base;
	data_t   sum;

	assign opcode = instr.b.opcode;
	assign funct3 = instr.b.funct3;

	wire rs_eq  = (rs1 == rs2);
	wire rs_lt  = ($signed(rs1) < $signed(rs2));
	wire rs_ltu = (rs1 < rs2);

	always_comb begin
		case (funct3)
			BEQ:     cond = rs_eq;
			BNE:     cond = ~rs_eq;
			BLT:     cond = rs_lt;
			BGE:     cond = ~rs_lt;
			BLTU:    cond = rs_ltu;
			BGEU:    cond = ~rs_ltu;
			default: cond = 1'b0; // 010/011 not a branch
		endcase
	end

	assign branch_taken = (opcode == B) && cond;

	// B and JAL offsets come in 2-byte steps, JALR in bytes
	assign imm  = get_imm(instr);
	assign base = (opcode == JALR) ? rs1 : pc;
	assign sum  = base + imm;

	// jalr drops bit 0 of the target
	assign pc_bj = (opcode == JALR) ? {sum[`XLEN_W-1:1], 1'b0} : sum;

	// 1 for branch/jump, 0 for pc + 4
	assign bj_sel = branch_taken || (opcode == JAL) || (opcode == JALR);

endmodule

// File: source/perf_counter.sv
module perf_counter import core_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  core_state_t state,
	input  logic        retire_valid,

	output data_t       cycle_count,
	output data_t       instret_count
);

	// start only counts when the fsm will take it
	wire restart = start && (state == IDLE || state == HALT);

	always_ff @(posedge clk) begin
		if (rst || restart) begin
			cycle_count   <= '0;
			instret_count <= '0;
		end else begin
			if (state == FETCH || state == EXEC)
				cycle_count <= cycle_count + 1'b1;
			if (retire_valid)
				instret_count <= instret_count + 1'b1;
		end
	end

	a_instret_le_cycle: assert property (@(posedge clk) disable iff (rst)
		instret_count <= cycle_count);

endmodule

// File: source/reg_file.sv
interface rf_if import core_pkg::*; ();
	logic [4:0] rs1_addr;
	logic [4:0] rs2_addr;
	data_t      rs1_data;
	data_t      rs2_data;
	logic       wr_en;
	logic [4:0] wr_addr;
	data_t      wr_data;

	modport core (
		output rs1_addr, rs2_addr, wr_en, wr_addr, wr_data,
		input  rs1_data, rs2_data
	);

	modport regs (
		input  rs1_addr, rs2_addr, wr_en, wr_addr, wr_data,
		output rs1_data, rs2_data
	);
endinterface

module reg_file import core_pkg::*; (
	input logic clk,
	input logic rst,
	rf_if.regs  rf
);

	data_t regs [32]; // entry 0 is x0, held at zero

	always_ff @(posedge clk) begin
		if (rst)
			regs[0] <= '0;
		else if (rf.wr_en && rf.wr_addr != 5'd0)
			regs[rf.wr_addr] <= rf.wr_data;
	end

	assign rf.rs1_data = regs[rf.rs1_addr];
	assign rf.rs2_data = regs[rf.rs2_addr];

	// x0 reads zero on both ports, whatever was written to it
	a_x0_zero: assert property (@(posedge clk) disable iff (rst)
		(rf.rs1_addr != 5'd0 || rf.rs1_data == '0) &&
		(rf.rs2_addr != 5'd0 || rf.rs2_data == '0));

endmodule

// File: source/rv_isa_pkg.sv
`include "core_defs.svh"

package rv_isa_pkg;

	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		B      = 7'b1100011,
		SYSTEM = 7'b1110011
	} opcode_t;

	// branch and alu codes share values, so plain constants
	typedef logic [2:0] funct3_t;
	localparam funct3_t BEQ     = 3'b000;
	localparam funct3_t BNE     = 3'b001;
	localparam funct3_t BLT     = 3'b100;
	localparam funct3_t BGE     = 3'b101;
	localparam funct3_t BLTU    = 3'b110;
	localparam funct3_t BGEU    = 3'b111;
	localparam funct3_t F3_ADD  = 3'b000; // add / sub
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SR   = 3'b101; // srl / sra
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		funct3_t    funct3;
		logic [4:0] rd;
		opcode_t    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		funct3_t     funct3;
		logic [4:0]  rd;
		opcode_t     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		funct3_t    funct3;
		logic [4:0] imm_4_0;
		opcode_t    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		funct3_t    funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		opcode_t    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		opcode_t     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		opcode_t    opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_t;

	// sign-extended immediate, format picked by opcode
	function automatic logic [`XLEN_W-1:0] get_imm(input instr_t instr);
		logic [`XLEN_W-1:0] imm;
		case (instr.r.opcode)
			OP_IMM, JALR, SYSTEM: imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
			B: imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
				instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
			LUI, AUIPC: imm = {instr.u.imm_31_12, 12'b0};
			JAL: imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
				instr.j.imm_11, instr.j.imm_10_1, 1'b0};
			default: imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
		endcase
		return imm;
	endfunction

endpackage

// File: sources.f
+incdir+source
source/rv_isa_pkg.sv
source/core_pkg.sv
source/reg_file.sv
source/instr_mem.sv
source/pc_adder.sv
source/alu.sv
source/core_fsm.sv
source/perf_counter.sv
source/core_top.sv
sim/core_tb.sv
